// ==== include/rv_div_defines.svh ====
`ifndef RV_DIV_DEFINES_SVH
`define RV_DIV_DEFINES_SVH

// data word width
`define LEN_WORD 32

// quotient bits per sub-step, so radix 16
`define DIV_BASE 4

// sub-steps needed for a full word
`define DIV_STEPS (`LEN_WORD / `DIV_BASE)

// register stages of two sub-steps each, equal to the latency
`define DIV_STAGES (`LEN_WORD / (2 * `DIV_BASE))

// bit positions inside the op field (low funct3 bits)
`define DIV_OP_UNS_BIT 0
`define DIV_OP_REM_BIT 1

`endif

// ==== rtl/rv_div_pkg.sv ====
`default_nettype none

`include "rv_div_defines.svh"

package rv_div_pkg;

    // operand or result word
    typedef logic [`LEN_WORD-1:0] word_t;

    // low funct3 bits
    // 00 DIV, 01 DIVU, 10 REM, 11 REMU
    typedef logic [1:0] div_op_t;

    // one divide request as issued by the core
    typedef struct packed {
        div_op_t op;
        word_t   rs1;
        word_t   rs2;
    } div_req_t;

endpackage

`default_nettype wire

// ==== rtl/temp_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

// register with load enable and synchronous clear
module temp_reg #(
    parameter int W = 1
) (
    input  wire          en,
    input  wire  [W-1:0] d,
    output logic [W-1:0] q,
    input  wire          clk,
    input  wire          rst
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/divu_remu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_div_defines.svh"

module divu_remu (
    input  wire                    order,
    output wire                    accepted,
    output wire                    done,
    input  wire rv_div_pkg::word_t rs1,
    input  wire rv_div_pkg::word_t rs2,
    input  wire                    rem_flag,
    output wire rv_div_pkg::word_t rd,
    input  wire                    clk,
    input  wire                    rst
);

    localparam int W      = `LEN_WORD;
    localparam int BASE   = `DIV_BASE;
    localparam int RADIX  = 2 ** BASE;
    localparam int STEPS  = `DIV_STEPS;
    localparam int STAGES = `DIV_STAGES;
    // compared window of the partial remainder, also the multiple width
    localparam int MW     = W + BASE;

    wire              busy;
    wire              next_busy;
    wire [STAGES:0]   stage;

    // partial remainder and quotient around each sub-step
    wire [2*W-1:0]    rem_in  [STEPS];
    wire [2*W-1:0]    rem_out [STEPS];
    wire [W-1:0]      quo_in  [STEPS];
    wire [W-1:0]      quo_out [STEPS];

    // divisor times 1..15, one copy per sub-step
    wire [MW-1:0]     mul [STEPS][RADIX-1];

    wire [2*W-1:0]    rem_final;

    // only one operation in flight
    assign accepted  = order & ~busy;
    assign next_busy = busy ? ~done : accepted;

    temp_reg #(.W(1)) r_busy (
        .en  (1'b1),
        .d   (next_busy),
        .q   (busy),
        .clk (clk),
        .rst (rst)
    );

    // one-hot token, bit n high while stage n works
    assign stage[0] = accepted;

    temp_reg #(.W(STAGES)) r_stage (
        .en  (1'b1),
        .d   (stage[STAGES-1:0]),
        .q   (stage[STAGES:1]),
        .clk (clk),
        .rst (rst)
    );

    assign done = stage[STAGES];

    // first sub-step works on the operands straight from the requester
    assign rem_in[0] = {{W{1'b0}}, rs1};
    assign quo_in[0] = '0;

    for (genvar j = 0; j < RADIX - 1; j++) begin : g_mul
        assign mul[0][j] = {{BASE{1'b0}}, rs2} * MW'(j + 1);
    end

    // registers after every second sub-step, plain wires in between
    for (genvar k = 1; k < STEPS; k++) begin : g_link
        if (k % 2 == 1) begin : g_reg
            // loads while the token sits in the stage just finished
            temp_reg #(.W(2*W)) r_rem (
                .en  (stage[k/2]),
                .d   (rem_out[k-1]),
                .q   (rem_in[k]),
                .clk (clk),
                .rst (1'b0)
            );

            temp_reg #(.W(W)) r_quo (
                .en  (stage[k/2]),
                .d   (quo_out[k-1]),
                .q   (quo_in[k]),
                .clk (clk),
                .rst (1'b0)
            );

            for (genvar j = 0; j < RADIX - 1; j++) begin : g_mul_reg
                temp_reg #(.W(MW)) r_mul (
                    .en  (stage[k/2]),
                    .d   (mul[k-1][j]),
                    .q   (mul[k][j]),
                    .clk (clk),
                    .rst (1'b0)
                );
            end
        end else begin : g_wire
            assign rem_in[k] = rem_out[k-1];
            assign quo_in[k] = quo_out[k-1];

            for (genvar j = 0; j < RADIX - 1; j++) begin : g_mul_wire
                assign mul[k][j] = mul[k-1][j];
            end
        end
    end

    // one radix-16 restoring step per k
    for (genvar k = 0; k < STEPS; k++) begin : g_step
        wire [MW-1:0]  top = rem_in[k][2*W-1 -: MW];
        wire [W-1:0]   quo_try [RADIX];
        wire [2*W-1:0] rem_try [RADIX];

        // digit zero, shift only
        assign quo_try[0] = {quo_in[k][W-BASE-1:0], {BASE{1'b0}}};
        assign rem_try[0] = {rem_in[k][2*W-BASE-1:0], {BASE{1'b0}}};

        // larger digits override, so the largest fitting multiple wins
        for (genvar i = 1; i < RADIX; i++) begin : g_digit
            wire          fits = top >= mul[k][i-1];
            wire [MW-1:0] diff = top - mul[k][i-1];

            assign quo_try[i] = fits ? {quo_in[k][W-BASE-1:0], BASE'(i)}
                                     : quo_try[i-1];
            assign rem_try[i] = fits ? {diff[W-1:0], rem_in[k][W-BASE-1:0], {BASE{1'b0}}}
                                     : rem_try[i-1];
        end

        assign quo_out[k] = quo_try[RADIX-1];
        assign rem_out[k] = rem_try[RADIX-1];
    end

    // the last sub-step settles in the done cycle
    // remainder ends up in the upper half
    assign rem_final = rem_out[STEPS-1];
    assign rd        = rem_flag ? rem_final[2*W-1:W] : quo_out[STEPS-1];

endmodule

`default_nettype wire

// ==== rtl/div_sign_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_div_defines.svh"

module div_sign_ctrl (
    input  wire rv_div_pkg::div_req_t req,
    input  wire                       accepted,
    input  wire rv_div_pkg::word_t    core_rd,
    output wire rv_div_pkg::word_t    core_rs1,
    output wire rv_div_pkg::word_t    core_rs2,
    output wire                       rem_flag,
    output wire rv_div_pkg::word_t    rd,
    input  wire                       clk,
    input  wire                       rst
);

    typedef struct packed {
        logic neg;       // two's complement the core result
        logic div_zero;  // signed DIV by zero
        logic rem;       // remainder wanted
    } flags_t;

    wire    is_rem;
    wire    is_uns;
    wire    sign1;
    wire    sign2;
    flags_t flags_d;
    flags_t flags_q;

    assign is_rem = req.op[`DIV_OP_REM_BIT];
    assign is_uns = req.op[`DIV_OP_UNS_BIT];

    // signs count only for DIV and REM
    assign sign1 = ~is_uns & req.rs1[`LEN_WORD-1];
    assign sign2 = ~is_uns & req.rs2[`LEN_WORD-1];

    // magnitudes into the core
    // most negative maps onto itself, which is the right unsigned magnitude
    assign core_rs1 = sign1 ? -req.rs1 : req.rs1;
    assign core_rs2 = sign2 ? -req.rs2 : req.rs2;

    // remainder follows the dividend sign
    assign flags_d.neg      = is_rem ? sign1 : (sign1 ^ sign2);
    assign flags_d.div_zero = ~is_rem & ~is_uns & (req.rs2 == '0);
    assign flags_d.rem      = is_rem;

    // captured once, the requester may move on after accepted
    temp_reg #(.W($bits(flags_t))) r_flags (
        .en  (accepted),
        .d   (flags_d),
        .q   (flags_q),
        .clk (clk),
        .rst (rst)
    );

    assign rem_flag = flags_q.rem;

    // signed divide by zero must give all ones whatever the dividend sign
    assign rd = flags_q.div_zero ? '1
              : flags_q.neg      ? -core_rd
              :                    core_rd;

endmodule

`default_nettype wire

// ==== rtl/div_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module div_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       order,
    input  wire rv_div_pkg::div_req_t req,
    output wire                       accepted,
    output wire                       done,
    output wire rv_div_pkg::word_t    rd
);

    rv_div_pkg::word_t core_rs1;
    rv_div_pkg::word_t core_rs2;
    rv_div_pkg::word_t core_rd;
    wire               rem_flag;

    // signed ops around the unsigned core
    div_sign_ctrl u_sign (
        .req      (req),
        .accepted (accepted),
        .core_rd  (core_rd),
        .core_rs1 (core_rs1),
        .core_rs2 (core_rs2),
        .rem_flag (rem_flag),
        .rd       (rd),
        .clk      (clk),
        .rst      (rst)
    );

    divu_remu u_core (
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .rs1      (core_rs1),
        .rs2      (core_rs2),
        .rem_flag (rem_flag),
        .rd       (core_rd),
        .clk      (clk),
        .rst      (rst)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_div_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_div_defines.svh"

module tb_div_unit;

    localparam int LATENCY    = `DIV_STAGES;
    localparam int WAIT_LIMIT = 20;
    localparam int IDLE_LIMIT = 100;
    localparam rv_div_pkg::word_t MOST_NEG = {1'b1, {(`LEN_WORD-1){1'b0}}};

    logic                   clk;
    logic                   rst;
    logic                   order;
    rv_div_pkg::div_req_t   req;
    wire                    accepted;
    wire                    done;
    wire rv_div_pkg::word_t rd;

    // accepted requests in order, written by the driver only
    rv_div_pkg::div_req_t   req_q[$];
    int                     acc_q[$];

    int          cycle = 0;
    logic [31:0] lcg_state;
    bit          all_sent = 1'b0;
    bit          compare_done = 1'b0;
    bit          busy_model = 1'b0;
    int          done_count = 0;
    int          value_errors = 0;
    int          timing_errors = 0;
    int          protocol_errors = 0;
    int          driver_errors = 0;
    int          checker_errors = 0;

    div_unit i_dut (
        .clk      (clk),
        .rst      (rst),
        .order    (order),
        .req      (req),
        .accepted (accepted),
        .done     (done),
        .rd       (rd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RISC-V M rules for DIV, DIVU, REM, REMU
    function automatic rv_div_pkg::word_t ref_result(input rv_div_pkg::div_op_t op,
                                                     input rv_div_pkg::word_t  a,
                                                     input rv_div_pkg::word_t  b);
        logic signed [`LEN_WORD-1:0] sa;
        logic signed [`LEN_WORD-1:0] sb;
        logic                        want_rem;
        logic                        unsigned_op;
        sa          = a;
        sb          = b;
        want_rem    = op[1];
        unsigned_op = op[0];
        // defined results instead of a trap
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        if (!unsigned_op && a == MOST_NEG && b == '1) begin
            return want_rem ? '0 : a;
        end
        if (unsigned_op) begin
            return want_rem ? a % b : a / b;
        end
        // truncating division, remainder keeps the dividend sign
        return want_rem ? sa % sb : sa / sb;
    endfunction

    task automatic random_operands(output rv_div_pkg::word_t a,
                                   output rv_div_pkg::word_t b,
                                   output logic              rem);
        logic [4:0] shift;
        logic       neg;
        lcg_state = lcg_next(lcg_state);
        a         = lcg_state;
        lcg_state = lcg_next(lcg_state);
        shift     = lcg_state[31:27];
        neg       = lcg_state[26];
        rem       = lcg_state[25];
        lcg_state = lcg_next(lcg_state);
        // shorter divisors give longer quotients
        b = lcg_state >> shift;
        if (neg) begin
            b = -b;
        end
    endtask

    // order stays high between requests, so the unit sees back-to-back work
    task automatic drive_request(input rv_div_pkg::div_op_t op,
                                 input rv_div_pkg::word_t  a,
                                 input rv_div_pkg::word_t  b,
                                 output int                wait_cycles);
        bit seen;
        seen        = 1'b0;
        wait_cycles = 0;
        @(posedge clk);
        #2;
        order   = 1'b1;
        req.op  = op;
        req.rs1 = a;
        req.rs2 = b;
        while (!seen && wait_cycles < WAIT_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
            seen = accepted;
        end
        if (seen) begin
            req_q.push_back(req);
            acc_q.push_back(cycle);
        end else begin
            $display("no accepted within %0d cycles for op %0d", WAIT_LIMIT, op);
            driver_errors++;
        end
    endtask

    // one operation in flight, one done per accept
    always @(negedge clk) begin
        if (!rst) begin
            if (accepted && busy_model) begin
                $display("FAIL %0t: accepted while an operation was in flight", $time);
                protocol_errors++;
            end
            if (done && !busy_model) begin
                $display("FAIL %0t: done without an accepted request", $time);
                protocol_errors++;
            end
            if (done) begin
                busy_model = 1'b0;
                done_count++;
            end
            if (accepted) begin
                busy_model = 1'b1;
            end
        end
    end

    initial begin : compare_results
        rv_div_pkg::div_req_t r;
        rv_div_pkg::word_t    expected;
        int                   idx;
        int                   idle;
        int                   waited;
        bit                   seen;
        idx  = 0;
        idle = 0;
        while (!(all_sent && idx == req_q.size()) && idle < IDLE_LIMIT) begin
            if (idx == req_q.size()) begin
                @(negedge clk);
                idle++;
            end else begin
                idle     = 0;
                waited   = 0;
                seen     = 1'b0;
                r        = req_q[idx];
                expected = ref_result(r.op, r.rs1, r.rs2);
                while (!seen && waited < WAIT_LIMIT) begin
                    @(negedge clk);
                    waited++;
                    seen = done;
                end
                if (!seen) begin
                    $display("no done within %0d cycles for request %0d", WAIT_LIMIT, idx);
                    checker_errors++;
                end else begin
                    if (rd !== expected) begin
                        $display("FAIL %0t: op=%0d rs1=%h rs2=%h expected %h got %h",
                                 $time, r.op, r.rs1, r.rs2, expected, rd);
                        value_errors++;
                    end
                    if (cycle - acc_q[idx] != LATENCY) begin
                        $display("FAIL %0t: done %0d cycles after accepted, expected %0d",
                                 $time, cycle - acc_q[idx], LATENCY);
                        timing_errors++;
                    end
                end
                idx++;
            end
        end
        if (idle >= IDLE_LIMIT) begin
            $display("no new request reached the checker for %0d cycles", IDLE_LIMIT);
            checker_errors++;
        end
        compare_done = 1'b1;
    end

    initial begin : run_tests
        rv_div_pkg::word_t a;
        rv_div_pkg::word_t b;
        logic              rem;
        int                wait_cycles;
        int                waited;
        int                i;
        int                k;
        rst       = 1'b1;
        order     = 1'b0;
        req       = '0;
        lcg_state = 32'd72;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle after reset
        repeat (4) begin
            @(negedge clk);
            if (done) begin
                $display("FAIL %0t: done high after reset with order low", $time);
                driver_errors++;
            end
        end

        drive_request(2'b01, 32'd1000, 32'd7, wait_cycles);
        if (wait_cycles != 1) begin
            $display("FAIL %0t: first request accepted after %0d cycles, expected 1",
                     $time, wait_cycles);
            driver_errors++;
        end

        for (i = 0; i < 200; i++) begin
            random_operands(a, b, rem);
            drive_request({rem, 1'b1}, a, b, wait_cycles);
        end
        for (i = 0; i < 200; i++) begin
            random_operands(a, b, rem);
            drive_request({rem, 1'b0}, a, b, wait_cycles);
        end

        // divide by zero with positive and negative dividends
        for (k = 0; k < 4; k++) begin
            drive_request(2'(k), 32'd12345, '0, wait_cycles);
            drive_request(2'(k), 32'hffff_fff9, '0, wait_cycles);
            drive_request(2'(k), MOST_NEG, '0, wait_cycles);
        end

        drive_request(2'b00, MOST_NEG, '1, wait_cycles);
        drive_request(2'b10, MOST_NEG, '1, wait_cycles);

        // same request held with order high
        repeat (3) drive_request(2'b10, 32'hffff_ff9c, 32'd7, wait_cycles);

        @(posedge clk);
        #2;
        order    = 1'b0;
        all_sent = 1'b1;

        waited = 0;
        while (!compare_done && waited < IDLE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!compare_done) begin
            $display("compare process did not finish within %0d cycles", IDLE_LIMIT);
            driver_errors++;
        end
        // stray done pulses would show up here
        repeat (4) @(negedge clk);
        if (done_count != req_q.size()) begin
            $display("FAIL %0t: %0d done pulses for %0d requests",
                     $time, done_count, req_q.size());
            driver_errors++;
        end

        $display("errors: value %0d, timing %0d, protocol %0d, driver %0d, checker %0d",
                 value_errors, timing_errors, protocol_errors, driver_errors, checker_errors);
        if (value_errors + timing_errors + protocol_errors + driver_errors
            + checker_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
rtl/rv_div_pkg.sv
rtl/temp_reg.sv
rtl/divu_remu.sv
rtl/div_sign_ctrl.sv
rtl/div_unit.sv
testbench/tb_div_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the divide unit testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module tb_div_unit \
    -f project.f -o tb_div_unit > build.log 2>&1 \
    && ./obj_dir/tb_div_unit > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "testbench reported failure"; exit 1; }
exit 0
